// ==== verilog/spi_cmd_pkg.sv ====
package spi_cmd_pkg;

  // Frame lengths are fixed by the command format.
  localparam int CMD_BITS = 12; // Bits shifted out on mosi per frame.
  localparam int RD_BITS  = 8;  // Bits clocked in from miso on a read.

  // Host command word, MSB first on the wire.
  typedef struct packed {
    logic       rw;   // 1 selects a write frame, 0 a read frame.
    logic [2:0] addr;
    logic [7:0] data;
  } spi_cmd_t;

  // Descriptor handed from decode to the shift engine.
  typedef struct packed {
    logic [CMD_BITS-1:0] bits;    // Word shifted out, MSB first.
    logic                is_read; // Append the read phase after the command.
    logic                tag;     // Ordering tag, carried through unchanged.
  } spi_frame_t;

endpackage

// ==== verilog/spi_link_pkg.sv ====
package spi_link_pkg;

  import spi_cmd_pkg::*;

  // Byte returned by a read frame.
  typedef struct packed {
    logic [RD_BITS-1:0] data;
  } spi_result_t;

  // Command channel, driven by the host against its credits.
  typedef struct packed {
    logic     valid;
    spi_cmd_t cmd;
  } spi_cmd_link_t;

  // Result channel, driven by the DUT against granted credits.
  typedef struct packed {
    logic        valid;
    spi_result_t res;
  } spi_res_link_t;

endpackage

// ==== verilog/spi_credit_fifo.sv ====
module spi_credit_fifo #(
  parameter int  DEPTH     = 4,
  parameter type payload_t = logic
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       push,
  input  payload_t                   push_data,
  input  logic                       pop,
  output payload_t                   pop_data,
  output logic                       empty,
  output logic [$clog2(DEPTH+1)-1:0] count
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign empty    = (count == '0);
  assign full     = (count == FULL_CNT);
  assign do_push  = push && !full; // Credits keep the writer from pushing when full.
  assign do_pop   = pop && !empty;
  assign pop_data = mem[rd_ptr];   // Head is visible without a pop.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

endmodule

// ==== verilog/spi_cmd_decode.sv ====
module spi_cmd_decode
  import spi_cmd_pkg::*;
  import spi_link_pkg::*;
#(
  parameter int CMD_DEPTH = 4
) (
  input  logic          clk,
  input  logic          rst_n,
  input  spi_cmd_link_t cmd_link,
  output logic          cmd_credit,
  output spi_frame_t    frame,
  output logic          frame_valid,
  input  logic          eng_busy,
  input  logic          res_reserve_ok,
  output logic          read_issued
);

  spi_cmd_t head;
  logic     q_empty;
  logic     issue;
  logic     tag_q;

  spi_credit_fifo #(
    .DEPTH     (CMD_DEPTH),
    .payload_t (spi_cmd_t)
  ) u_cmd_q (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (cmd_link.valid),
    .push_data (cmd_link.cmd),
    .pop       (issue),
    .pop_data  (head),
    .empty     (q_empty),
    .count     ()
  );

  // A read waits at the head until a result slot is reserved, so later writes wait too.
  assign issue = !q_empty && !eng_busy && !frame_valid && (head.rw || res_reserve_ok);

  assign cmd_credit = frame_valid; // The queue entry is freed as the frame is handed over.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      frame_valid <= 1'b0;
      read_issued <= 1'b0;
      tag_q       <= 1'b0;
    end
    else
    begin
      frame_valid <= issue;
      read_issued <= issue && !head.rw;
      if (issue)
        tag_q <= ~tag_q; // Alternates per frame.
    end
  end

  always_ff @(posedge clk)
  begin
    if (issue)
      frame <= '{bits: head, is_read: !head.rw, tag: tag_q};
  end

endmodule

// ==== verilog/spi_shift_engine.sv ====
module spi_shift_engine
  import spi_cmd_pkg::*;
  import spi_link_pkg::*;
#(
  parameter int SCLK_DIV = 4
) (
  input  logic        clk,
  input  logic        rst_n,
  input  spi_frame_t  frame,
  input  logic        frame_valid,
  output logic        eng_busy,
  output logic        sclk,
  output logic        cs,
  output logic        mosi,
  input  logic        miso,
  output spi_result_t rd_result,
  output logic        rd_valid
);

  localparam int DIV_W = $clog2(SCLK_DIV);
  localparam int BIT_W = $clog2(CMD_BITS);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SCLK_DIV - 1);
  localparam logic [BIT_W-1:0] OUT_LAST = BIT_W'(CMD_BITS - 1);
  localparam logic [BIT_W-1:0] IN_LAST  = BIT_W'(RD_BITS - 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SETUP,
    ST_SHIFT_OUT,
    ST_SHIFT_IN,
    ST_FINISH
  } state_t;

  state_t              state;
  logic [DIV_W-1:0]    div_cnt;
  logic [BIT_W-1:0]    bit_cnt;
  logic                tick;
  logic                rd_mode;
  logic [CMD_BITS-1:0] out_sr;
  logic [RD_BITS-1:0]  in_sr;

  assign tick     = (div_cnt == DIV_LAST); // End of an sclk half period.
  assign eng_busy = (state != ST_IDLE);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      div_cnt <= '0;
    else if (state == ST_IDLE || tick)
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= ST_IDLE;
      cs       <= 1'b1;
      sclk     <= 1'b0;
      mosi     <= 1'b0;
      bit_cnt  <= '0;
      rd_mode  <= 1'b0;
      rd_valid <= 1'b0;
    end
    else
    begin
      rd_valid <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (frame_valid)
          begin
            cs      <= 1'b0;
            mosi    <= frame.bits[CMD_BITS-1];
            rd_mode <= frame.is_read;
            bit_cnt <= '0;
            state   <= ST_SETUP;
          end
        end
        ST_SETUP:
        begin
          if (tick)
          begin
            sclk  <= 1'b1; // The slave samples the MSB here.
            state <= ST_SHIFT_OUT;
          end
        end
        ST_SHIFT_OUT:
        begin
          if (tick)
          begin
            sclk <= ~sclk;
            if (sclk)
            begin
              if (bit_cnt == OUT_LAST)
              begin
                mosi    <= 1'b0;
                bit_cnt <= '0;
                state   <= rd_mode ? ST_SHIFT_IN : ST_FINISH;
              end
              else
              begin
                mosi    <= out_sr[CMD_BITS-2]; // Next bit after the falling edge.
                bit_cnt <= bit_cnt + 1'b1;
              end
            end
          end
        end
        ST_SHIFT_IN:
        begin
          if (tick)
          begin
            sclk <= ~sclk;
            if (sclk)
            begin
              if (bit_cnt == IN_LAST)
                state <= ST_FINISH;
              else
                bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        ST_FINISH:
        begin
          if (tick)
          begin
            cs       <= 1'b1;
            rd_valid <= rd_mode;
            state    <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == ST_IDLE && frame_valid)
      out_sr <= frame.bits;
    else if (state == ST_SHIFT_OUT && tick && sclk)
      out_sr <= out_sr << 1;
    if (state == ST_SHIFT_IN && tick && !sclk)
      in_sr <= {in_sr[RD_BITS-2:0], miso}; // Sampled with the rising edge.
    if (state == ST_FINISH && tick)
      rd_result.data <= in_sr;
  end

endmodule

// ==== verilog/spi_read_collect.sv ====
module spi_read_collect
  import spi_link_pkg::*;
#(
  parameter int RES_DEPTH = 2
) (
  input  logic          clk,
  input  logic          rst_n,
  input  spi_result_t   rd_result,
  input  logic          rd_valid,
  input  logic          read_issued,
  output logic          res_reserve_ok,
  input  logic          res_credit,
  output spi_res_link_t res_link
);

  localparam int CNT_W    = $clog2(RES_DEPTH + 1);
  localparam int SUM_W    = CNT_W + 1;
  localparam int CREDIT_W = 16;
  localparam logic [SUM_W-1:0] SLOTS = SUM_W'(RES_DEPTH);

  logic [CNT_W-1:0]    q_count;
  logic [CNT_W-1:0]    in_flight;
  logic [CREDIT_W-1:0] credits;
  logic                q_empty;
  logic                send;
  logic                valid_q;
  spi_result_t         head;
  spi_result_t         res_q;

  spi_credit_fifo #(
    .DEPTH     (RES_DEPTH),
    .payload_t (spi_result_t)
  ) u_res_q (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (rd_valid),
    .push_data (rd_result),
    .pop       (send),
    .pop_data  (head),
    .empty     (q_empty),
    .count     (q_count)
  );

  assign send           = !q_empty && (credits != '0);
  assign res_reserve_ok = ({1'b0, q_count} + {1'b0, in_flight}) < SLOTS; // Room for one more read.
  assign res_link       = '{valid: valid_q, res: res_q};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      in_flight <= '0;
      credits   <= '0;
      valid_q   <= 1'b0;
    end
    else
    begin
      case ({read_issued, rd_valid})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;
        default: in_flight <= in_flight;
      endcase
      credits <= credits + CREDIT_W'(res_credit) - CREDIT_W'(send);
      valid_q <= send;
    end
  end

  always_ff @(posedge clk)
  begin
    if (send)
      res_q <= head;
  end

endmodule

// ==== verilog/spi_cmd_master.sv ====
module spi_cmd_master
  import spi_cmd_pkg::*;
  import spi_link_pkg::*;
#(
  parameter int CMD_DEPTH = 4,
  parameter int RES_DEPTH = 2,
  parameter int SCLK_DIV  = 4
) (
  input  logic          clk,
  input  logic          rst_n,
  input  spi_cmd_link_t cmd_link,
  output logic          cmd_credit,
  input  logic          res_credit,
  output spi_res_link_t res_link,
  output logic          sclk,
  output logic          cs,
  output logic          mosi,
  input  logic          miso
);

  spi_frame_t  frame;
  spi_result_t rd_result;
  logic        frame_valid;
  logic        eng_busy;
  logic        res_reserve_ok;
  logic        read_issued;
  logic        rd_valid;

  spi_cmd_decode #(
    .CMD_DEPTH (CMD_DEPTH)
  ) u_decode (
    .clk            (clk),
    .rst_n          (rst_n),
    .cmd_link       (cmd_link),
    .cmd_credit     (cmd_credit),
    .frame          (frame),
    .frame_valid    (frame_valid),
    .eng_busy       (eng_busy),
    .res_reserve_ok (res_reserve_ok),
    .read_issued    (read_issued)
  );

  spi_shift_engine #(
    .SCLK_DIV (SCLK_DIV)
  ) u_execute (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame       (frame),
    .frame_valid (frame_valid),
    .eng_busy    (eng_busy),
    .sclk        (sclk),
    .cs          (cs),
    .mosi        (mosi),
    .miso        (miso),
    .rd_result   (rd_result),
    .rd_valid    (rd_valid)
  );

  spi_read_collect #(
    .RES_DEPTH (RES_DEPTH)
  ) u_result (
    .clk            (clk),
    .rst_n          (rst_n),
    .rd_result      (rd_result),
    .rd_valid       (rd_valid),
    .read_issued    (read_issued),
    .res_reserve_ok (res_reserve_ok),
    .res_credit     (res_credit),
    .res_link       (res_link)
  );

endmodule

// ==== dv/spi_tb_clk.sv ====
module spi_tb_clk #(
  parameter int PERIOD_NS = 8
) (
  output logic clk
);

  timeunit 1ns;
  timeprecision 1ps;

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

// ==== dv/spi_cmd_master_tb.sv ====
module spi_cmd_master_tb
  import spi_cmd_pkg::*;
  import spi_link_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CMD_DEPTH       = 4;
  localparam int RES_DEPTH       = 2;
  localparam int SCLK_DIV        = 4;
  localparam int NUM_CMDS        = 40;
  localparam int RESET_CYCLES    = 16;
  localparam int DRIVE_DELAY     = 1;
  localparam int WITHHOLD_CYCLES = 600;
  localparam int FRAME_BITS      = CMD_BITS + RD_BITS;
  localparam int TIMEOUT_CYCLES  = NUM_CMDS * (FRAME_BITS * 2 * SCLK_DIV + 50);

  logic          clk;
  logic          rst_n;
  spi_cmd_link_t cmd_link;
  logic          cmd_credit;
  logic          res_credit;
  spi_res_link_t res_link;
  logic          sclk;
  logic          cs;
  logic          mosi;
  logic          miso;

  spi_cmd_t       exp_frames[$]; // Commands in the order the host sent them.
  logic [7:0]     exp_res[$];    // One entry per read, in command order.
  int             host_credits;
  int             sent;
  int             reads_sent;
  int             results_seen;
  int             credits_granted;
  int             cmd_credits_seen;
  int             frames_checked;
  logic           withhold;

  logic [CMD_BITS-1:0] mosi_bits = '0;
  logic [7:0]          reply     = '0;
  int                  rises     = 0;
  logic                in_frame  = 1'b0;

  spi_tb_clk u_clk (
    .clk (clk)
  );

  spi_cmd_master #(
    .CMD_DEPTH (CMD_DEPTH),
    .RES_DEPTH (RES_DEPTH),
    .SCLK_DIV  (SCLK_DIV)
  ) u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_link   (cmd_link),
    .cmd_credit (cmd_credit),
    .res_credit (res_credit),
    .res_link   (res_link),
    .sclk       (sclk),
    .cs         (cs),
    .mosi       (mosi),
    .miso       (miso)
  );

  // The slave answers a read with the data field scrambled by a fixed mask.
  function automatic logic [7:0] expected_reply(spi_cmd_t c);
    return c.data ^ 8'hA5;
  endfunction

  task automatic check_value(string what, int got, int expected);
    if (got != expected)
    begin
      $display("** Error at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, expected);
      $display("RESULT: FAIL");
      $fatal(1);
    end
  endtask

  task automatic send_commands();
    spi_cmd_t c;
    while (sent < NUM_CMDS)
    begin
      @(posedge clk);
      #DRIVE_DELAY;
      cmd_link = '0;
      if (host_credits > 0 && $urandom_range(0, 3) != 0)
      begin
        c.rw   = 1'($urandom_range(0, 1));
        c.addr = 3'($urandom_range(0, 7));
        c.data = 8'($urandom);
        cmd_link = '{valid: 1'b1, cmd: c};
        host_credits--;
        exp_frames.push_back(c);
        if (!c.rw)
        begin
          exp_res.push_back(expected_reply(c));
          reads_sent++;
        end
        sent++;
      end
    end
    @(posedge clk);
    #DRIVE_DELAY cmd_link = '0;
  endtask

  task automatic grant_results();
    int gap;
    int burst;
    withhold = 1'b1; // Long stretch with no result credits at all.
    repeat (WITHHOLD_CYCLES) @(posedge clk);
    withhold = 1'b0;
    while (frames_checked < NUM_CMDS)
    begin
      gap = $urandom_range(0, 20);
      repeat (gap) @(posedge clk);
      burst = $urandom_range(1, 4);
      repeat (burst)
      begin
        @(posedge clk);
        #DRIVE_DELAY res_credit = 1'b1;
      end
      @(posedge clk);
      #DRIVE_DELAY res_credit = 1'b0;
    end
    // All reads are done on the wire, so at most RES_DEPTH results still wait.
    repeat (RES_DEPTH)
    begin
      @(posedge clk);
      #DRIVE_DELAY res_credit = 1'b1;
    end
    @(posedge clk);
    #DRIVE_DELAY res_credit = 1'b0;
  endtask

  // SPI slave, mode 0.
  always @(negedge cs)
  begin
    in_frame  = 1'b1;
    rises     = 0;
    mosi_bits = '0;
  end

  always @(posedge sclk)
  begin
    if (!cs && in_frame)
    begin
      if (rises < CMD_BITS)
        mosi_bits = {mosi_bits[CMD_BITS-2:0], mosi};
      rises++;
    end
  end

  always @(negedge sclk)
  begin
    if (!cs && in_frame && rises >= CMD_BITS && rises < FRAME_BITS)
    begin
      if (rises == CMD_BITS)
        reply = expected_reply(spi_cmd_t'(mosi_bits));
      miso = reply[FRAME_BITS-1-rises]; // Next reply bit after the falling edge.
    end
  end

  always @(posedge cs)
  begin
    if (in_frame)
    begin
      in_frame = 1'b0;
      check_value("frame expected from the host", int'(exp_frames.size() > 0), 1);
      check_value("frame command word", int'(mosi_bits), int'(exp_frames[0]));
      check_value("sclk rises in frame", rises, exp_frames[0].rw ? CMD_BITS : FRAME_BITS);
      void'(exp_frames.pop_front());
      frames_checked++;
    end
  end

  always @(negedge clk)
  begin
    if (rst_n && cmd_credit)
    begin
      cmd_credits_seen++;
      host_credits++;
      check_value("host command credits within depth", int'(host_credits <= CMD_DEPTH), 1);
    end
  end

  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (res_credit)
        credits_granted++;
      if (res_link.valid)
      begin
        check_value("result while credits withheld", int'(withhold), 0);
        results_seen++;
        check_value("results within granted credits", int'(results_seen <= credits_granted), 1);
        check_value("result expected for a read", int'(exp_res.size() > 0), 1);
        check_value("read result", int'(res_link.res.data), int'(exp_res[0]));
        void'(exp_res.pop_front());
      end
    end
  end

  initial
  begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles.", TIMEOUT_CYCLES);
    $display("RESULT: FAIL");
    $fatal(1);
  end

  initial
  begin
    void'($urandom(32'h3157));
    rst_n            = 1'b0;
    cmd_link         = '0;
    res_credit       = 1'b0;
    miso             = 1'b0;
    host_credits     = CMD_DEPTH;
    sent             = 0;
    reads_sent       = 0;
    results_seen     = 0;
    credits_granted  = 0;
    cmd_credits_seen = 0;
    frames_checked   = 0;
    withhold         = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY rst_n = 1'b1;
    repeat (2) @(negedge clk);
    check_value("cs idle level", int'(cs), 1);
    check_value("sclk idle level", int'(sclk), 0);
    check_value("mosi idle level", int'(mosi), 0);
    check_value("cmd_credit after reset", int'(cmd_credit), 0);
    check_value("res_link.valid after reset", int'(res_link.valid), 0);
    fork
      send_commands();
      grant_results();
    join
    repeat (50) @(posedge clk); // The last results drain and any stray one shows up.
    check_value("cmd_credit pulses", cmd_credits_seen, NUM_CMDS);
    check_value("results delivered", results_seen, reads_sent);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== compile.f ====
verilog/spi_cmd_pkg.sv
verilog/spi_link_pkg.sv
verilog/spi_credit_fifo.sv
verilog/spi_cmd_decode.sv
verilog/spi_shift_engine.sv
verilog/spi_read_collect.sv
verilog/spi_cmd_master.sv
dv/spi_tb_clk.sv
dv/spi_cmd_master_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing -Wno-fatal
TOP        ?= spi_cmd_master_tb
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := RESULT: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
